//--- filelist.f
+incdir+verilog
verilog/soc_pkg.sv
verilog/soc_bus_ctrl.sv
verilog/l2_mem.sv
verilog/apb_uart_bridge.sv
verilog/ctrl_regs.sv
verilog/soc_top.sv
testbench/soc_assertions.sv
testbench/tb_soc_top.sv

//--- Makefile
TOP := tb_soc_top
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f

# Pass only if the log holds the pass line
run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/tb_soc_top.sv
// SoC bus fabric testbench
`timescale 1ns/100ps
`include "soc_defines.svh"

module tb_soc_top;

  // About 70 requests of at most 8 cycles each, with a wide margin
  localparam int TIMEOUT_CYCLES = 5000;

  logic                   clk_i;
  logic                   rst_i;
  logic                   req_valid_i;
  logic                   req_we_i;
  logic [`SOC_ADDR_W-1:0] req_addr_i;
  logic [`SOC_DATA_W-1:0] req_wdata_i;
  logic [`SOC_STRB_W-1:0] req_be_i;
  logic                   rsp_valid_o;
  logic [`SOC_DATA_W-1:0] rsp_rdata_o;
  logic                   rsp_err_o;
  logic [`SOC_DATA_W-1:0] exit_o;
  logic [`SOC_DATA_W-1:0] hw_cnt_en_o;
  logic                   uart_psel_o;
  logic                   uart_penable_o;
  logic                   uart_pwrite_o;
  logic [`SOC_ADDR_W-1:0] uart_paddr_o;
  logic [`APB_DATA_W-1:0] uart_pwdata_o;
  logic [`APB_DATA_W-1:0] uart_prdata_i;
  logic                   uart_pready_i;
  logic                   uart_pslverr_i;

  integer                 seed = 32'hd46ffb4e;
  int                     errors;
  int                     apb_errors;
  int                     apb_xfers;
  int                     cycles;
  logic [`SOC_DATA_W-1:0] l2_model [`L2_WORDS];
  logic [`APB_DATA_W-1:0] apb_regs [16];
  logic [`SOC_ADDR_W-1:0] apb_exp_paddr;
  logic                   apb_exp_write;
  logic [`APB_DATA_W-1:0] apb_exp_wdata;

  soc_top i_soc_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout after %0d cycles, a response never arrived", cycles);
    $display("TESTS FAILED");
    $finish;
  end

  //////////////////////
  // APB slave model
  //////////////////////

  initial begin : apb_slave
    logic [1:0] waits;
    logic [3:0] slot;
    uart_prdata_i  = '0;
    uart_pready_i  = 1'b0;
    uart_pslverr_i = 1'b0;
    waits          = '0;
    apb_xfers      = 0;
    apb_errors     = 0;
    for (int i = 0; i < 16; i++) begin
      apb_regs[i] = 32'h3c00_0000 ^ (32'(i) * 32'h0101_0101);
    end
    forever begin
      @(negedge clk_i);
      uart_pready_i  = 1'b0;
      uart_pslverr_i = 1'b0;
      if (uart_psel_o && !uart_penable_o) begin
        apb_xfers++;
        waits = 2'($random(seed));
        if (uart_paddr_o !== apb_exp_paddr)
          flag_mismatch("uart_paddr_o", 64'(uart_paddr_o), 64'(apb_exp_paddr), apb_errors);
        if (uart_pwrite_o !== apb_exp_write)
          flag_mismatch("uart_pwrite_o", 64'(uart_pwrite_o), 64'(apb_exp_write), apb_errors);
        if (apb_exp_write && uart_pwdata_o !== apb_exp_wdata)
          flag_mismatch("uart_pwdata_o", 64'(uart_pwdata_o), 64'(apb_exp_wdata), apb_errors);
      end else if (uart_psel_o && uart_penable_o) begin
        if (waits != 2'd0) begin
          waits--;
        end else begin
          slot          = uart_paddr_o[5:2];
          uart_pready_i = 1'b1;
          if (uart_paddr_o[11:0] == 12'hffc) begin
            uart_pslverr_i = 1'b1;
          end else if (uart_pwrite_o) begin
            apb_regs[slot] = uart_pwdata_o;
          end
          uart_prdata_i = apb_regs[slot];
        end
      end
    end
  end

  //////////////////////
  // Helpers
  //////////////////////

  task automatic flag_mismatch(input string name, input logic [63:0] got,
                               input logic [63:0] exp, inout int count);
    $display("ERROR: %s got %h expected %h", name, got, exp);
    count++;
  endtask

  function automatic logic [63:0] merge_bytes(input logic [63:0] old_v,
                                              input logic [63:0] new_v,
                                              input logic [7:0] be);
    logic [63:0] mask;
    for (int b = 0; b < 8; b++) begin
      mask[8*b +: 8] = {8{be[b]}};
    end
    return (old_v & ~mask) | (new_v & mask);
  endfunction

  function automatic logic in_uart(input logic [31:0] addr);
    return (addr >= `UART_BASE) && (addr < `UART_BASE + `PERIPH_LEN);
  endfunction

  // One strobe, then wait for the response and check its timing and error flag
  task automatic issue_request(input logic we, input logic [31:0] addr,
                               input logic [63:0] wdata, input logic [7:0] be,
                               input logic exp_err, output logic [63:0] rdata);
    int lat;
    @(negedge clk_i);
    req_valid_i = 1'b1;
    req_we_i    = we;
    req_addr_i  = addr;
    req_wdata_i = wdata;
    req_be_i    = be;
    @(negedge clk_i);
    req_valid_i = 1'b0;
    lat         = 1;
    while (!rsp_valid_o) begin
      @(negedge clk_i);
      lat++;
    end
    rdata = rsp_rdata_o;
    if (!in_uart(addr) && lat != 2)
      flag_mismatch("rsp_valid_o latency", 64'(lat), 64'd2, errors);
    if (rsp_err_o !== exp_err)
      flag_mismatch("rsp_err_o", 64'(rsp_err_o), 64'(exp_err), errors);
    if (exp_err && rsp_rdata_o !== '0)
      flag_mismatch("rsp_rdata_o", rsp_rdata_o, 64'h0, errors);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [63:0] data,
                           input logic [7:0] be, input logic exp_err);
    logic [63:0] unused;
    issue_request(1'b1, addr, data, be, exp_err, unused);
  endtask

  task automatic bus_read(input logic [31:0] addr, input logic exp_err,
                          output logic [63:0] rdata);
    issue_request(1'b0, addr, '0, '0, exp_err, rdata);
  endtask

  //////////////////////
  // Tests
  //////////////////////

  task automatic test_reset();
    if (rsp_valid_o !== 1'b0) flag_mismatch("rsp_valid_o", 64'(rsp_valid_o), 64'h0, errors);
    if (uart_psel_o !== 1'b0) flag_mismatch("uart_psel_o", 64'(uart_psel_o), 64'h0, errors);
    if (uart_penable_o !== 1'b0)
      flag_mismatch("uart_penable_o", 64'(uart_penable_o), 64'h0, errors);
    if (exit_o !== '0) flag_mismatch("exit_o", exit_o, 64'h0, errors);
    if (hw_cnt_en_o !== '0) flag_mismatch("hw_cnt_en_o", hw_cnt_en_o, 64'h0, errors);
  endtask

  task automatic test_l2();
    logic [9:0]  idx [12];
    logic [31:0] addr;
    logic [63:0] data;
    logic [63:0] got;
    logic [7:0]  be;
    idx[0] = 10'd0;
    idx[1] = 10'h3ff;
    for (int i = 2; i < 12; i++) begin
      idx[i] = 10'($random(seed));
    end
    // Full words first so no byte stays unknown
    for (int i = 0; i < 12; i++) begin
      addr = `DRAM_BASE + {19'b0, idx[i], 3'b000};
      data = {$random(seed), $random(seed)};
      bus_write(addr, data, 8'hff, 1'b0);
      l2_model[idx[i]] = data;
    end
    for (int i = 0; i < 12; i++) begin
      addr = `DRAM_BASE + {19'b0, idx[i], 3'b000};
      data = {$random(seed), $random(seed)};
      be   = 8'($random(seed));
      bus_write(addr, data, be, 1'b0);
      l2_model[idx[i]] = merge_bytes(l2_model[idx[i]], data, be);
    end
    for (int i = 0; i < 12; i++) begin
      bus_read(`DRAM_BASE + {19'b0, idx[i], 3'b000}, 1'b0, got);
      if (got !== l2_model[idx[i]]) flag_mismatch("rsp_rdata_o", got, l2_model[idx[i]], errors);
    end
  endtask

  task automatic test_ctrl();
    logic [31:0] exit_addr;
    logic [31:0] cnt_addr;
    logic [63:0] exp_exit;
    logic [63:0] exp_cnt;
    logic [63:0] data;
    logic [63:0] got;
    exit_addr = `CTRL_BASE + 32'(`CTRL_EXIT_OFS);
    cnt_addr  = `CTRL_BASE + 32'(`CTRL_CNT_EN_OFS);
    exp_exit  = '0;
    exp_cnt   = '0;
    data = {$random(seed), $random(seed)};
    bus_write(exit_addr, data, 8'hff, 1'b0);
    exp_exit = data;
    data = {$random(seed), $random(seed)};
    bus_write(exit_addr, data, 8'h0f, 1'b0);
    exp_exit = merge_bytes(exp_exit, data, 8'h0f);
    if (exit_o !== exp_exit) flag_mismatch("exit_o", exit_o, exp_exit, errors);
    data = {$random(seed), $random(seed)};
    bus_write(cnt_addr, data, 8'ha5, 1'b0);
    exp_cnt = merge_bytes(exp_cnt, data, 8'ha5);
    if (hw_cnt_en_o !== exp_cnt) flag_mismatch("hw_cnt_en_o", hw_cnt_en_o, exp_cnt, errors);
    bus_read(exit_addr, 1'b0, got);
    if (got !== exp_exit) flag_mismatch("rsp_rdata_o", got, exp_exit, errors);
    bus_read(cnt_addr, 1'b0, got);
    if (got !== exp_cnt) flag_mismatch("rsp_rdata_o", got, exp_cnt, errors);
    // Unused offset
    bus_write(`CTRL_BASE + 32'h010, {$random(seed), $random(seed)}, 8'hff, 1'b0);
    bus_read(`CTRL_BASE + 32'h010, 1'b0, got);
    if (got !== '0) flag_mismatch("rsp_rdata_o", got, 64'h0, errors);
    if (exit_o !== exp_exit) flag_mismatch("exit_o", exit_o, exp_exit, errors);
    if (hw_cnt_en_o !== exp_cnt) flag_mismatch("hw_cnt_en_o", hw_cnt_en_o, exp_cnt, errors);
  endtask

  task automatic test_uart();
    logic [11:0] ofs [4];
    logic [31:0] half [4];
    logic [63:0] data;
    logic [63:0] exp;
    logic [63:0] got;
    ofs[0] = 12'h000;
    ofs[1] = 12'h004;
    ofs[2] = 12'h010;
    ofs[3] = 12'h01c;
    apb_exp_write = 1'b1;
    for (int i = 0; i < 4; i++) begin
      data          = {$random(seed), $random(seed)};
      half[i]       = ofs[i][2] ? data[63:32] : data[31:0];
      apb_exp_paddr = `UART_BASE + 32'(ofs[i]);
      apb_exp_wdata = half[i];
      bus_write(`UART_BASE + 32'(ofs[i]), data, 8'hff, 1'b0);
    end
    apb_exp_write = 1'b0;
    for (int i = 0; i < 4; i++) begin
      apb_exp_paddr = `UART_BASE + 32'(ofs[i]);
      exp = ofs[i][2] ? {half[i], 32'h0} : {32'h0, half[i]};
      bus_read(`UART_BASE + 32'(ofs[i]), 1'b0, got);
      if (got !== exp) flag_mismatch("rsp_rdata_o", got, exp, errors);
    end
  endtask

  task automatic test_errors();
    logic [31:0] bad [5];
    logic [63:0] exit0;
    logic [63:0] cnt0;
    logic [63:0] got;
    int          xfers0;
    // Slave error from the UART
    apb_exp_paddr = `UART_BASE + 32'h0000_0ffc;
    apb_exp_write = 1'b1;
    apb_exp_wdata = 32'h0bad_cafe;
    bus_write(`UART_BASE + 32'h0000_0ffc, 64'h0bad_cafe_0bad_cafe, 8'hff, 1'b1);
    apb_exp_write = 1'b0;
    bus_read(`UART_BASE + 32'h0000_0ffc, 1'b1, got);
    // Just outside each region, and far away
    bad[0] = 32'h0000_0000;
    bad[1] = `DRAM_BASE + `DRAM_LEN;
    bad[2] = `UART_BASE + `PERIPH_LEN;
    bad[3] = `CTRL_BASE + `PERIPH_LEN;
    bad[4] = 32'hf000_0000;
    exit0  = exit_o;
    cnt0   = hw_cnt_en_o;
    xfers0 = apb_xfers;
    for (int i = 0; i < 5; i++) begin
      bus_write(bad[i], {$random(seed), $random(seed)}, 8'hff, 1'b1);
      bus_read(bad[i], 1'b1, got);
    end
    if (apb_xfers != xfers0) begin
      $display("APB transfer started for an unmapped address");
      errors++;
    end
    if (exit_o !== exit0) flag_mismatch("exit_o", exit_o, exit0, errors);
    if (hw_cnt_en_o !== cnt0) flag_mismatch("hw_cnt_en_o", hw_cnt_en_o, cnt0, errors);
    bus_read(`DRAM_BASE, 1'b0, got);
    if (got !== l2_model[0]) flag_mismatch("rsp_rdata_o", got, l2_model[0], errors);
  endtask

  //////////////////////
  // Sequence
  //////////////////////

  initial begin
    rst_i         = 1'b1;
    req_valid_i   = 1'b0;
    req_we_i      = 1'b0;
    req_addr_i    = '0;
    req_wdata_i   = '0;
    req_be_i      = '0;
    apb_exp_paddr = '0;
    apb_exp_write = 1'b0;
    apb_exp_wdata = '0;
    errors        = 0;
    repeat (10) @(negedge clk_i);
    rst_i = 1'b0;
    test_reset();
    test_l2();
    test_ctrl();
    test_uart();
    test_errors();
    $display("Run complete with %0d errors, %0d of them from the APB model",
             errors + apb_errors, apb_errors);
    if (errors + apb_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_soc_top

//--- testbench/soc_assertions.sv
// Bus protocol assertions
`timescale 1ns/100ps
`include "soc_defines.svh"

module soc_assertions (
  input logic                   clk_i,
  input logic                   rst_i,
  input logic                   rsp_valid_i,
  input logic                   l2_req_i,
  input logic                   uart_req_i,
  input logic                   ctrl_req_i,
  input logic                   psel_i,
  input logic                   penable_i,
  input logic                   pwrite_i,
  input logic [`SOC_ADDR_W-1:0] paddr_i,
  input logic                   pready_i
);

  // Response is a one-cycle strobe
  rsp_single: assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_valid_i |=> !rsp_valid_i)
    else $error("rsp_valid_o high two cycles in a row");

  target_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({l2_req_i, uart_req_i, ctrl_req_i}))
    else $error("more than one target strobe high");

  penable_sel: assert property (@(posedge clk_i) disable iff (rst_i)
    penable_i |-> psel_i)
    else $error("penable high without psel");

  // Held from setup until the access cycle with pready
  apb_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    (psel_i && !(penable_i && pready_i)) |=> (psel_i && $stable(pwrite_i) && $stable(paddr_i)))
    else $error("APB transfer changed before pready");

endmodule : soc_assertions

bind soc_top soc_assertions i_soc_assertions (
  .clk_i      (clk_i         ),
  .rst_i      (rst_i         ),
  .rsp_valid_i(rsp_valid_o   ),
  .l2_req_i   (l2_req        ),
  .uart_req_i (uart_req      ),
  .ctrl_req_i (ctrl_req      ),
  .psel_i     (uart_psel_o   ),
  .penable_i  (uart_penable_o),
  .pwrite_i   (uart_pwrite_o ),
  .paddr_i    (uart_paddr_o  ),
  .pready_i   (uart_pready_i )
);

//--- verilog/soc_top.sv
// SoC bus fabric top
`timescale 1ns/100ps
`include "soc_defines.svh"

module soc_top (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_valid_i,
  input  logic                   req_we_i,
  input  logic [`SOC_ADDR_W-1:0] req_addr_i,
  input  logic [`SOC_DATA_W-1:0] req_wdata_i,
  input  logic [`SOC_STRB_W-1:0] req_be_i,
  output logic                   rsp_valid_o,
  output logic [`SOC_DATA_W-1:0] rsp_rdata_o,
  output logic                   rsp_err_o,
  output logic [`SOC_DATA_W-1:0] exit_o,
  output logic [`SOC_DATA_W-1:0] hw_cnt_en_o,
  output logic                   uart_psel_o,
  output logic                   uart_penable_o,
  output logic                   uart_pwrite_o,
  output logic [`SOC_ADDR_W-1:0] uart_paddr_o,
  output logic [`APB_DATA_W-1:0] uart_pwdata_o,
  input  logic [`APB_DATA_W-1:0] uart_prdata_i,
  input  logic                   uart_pready_i,
  input  logic                   uart_pslverr_i
);

  logic                   l2_req;
  logic                   l2_done;
  logic [`SOC_DATA_W-1:0] l2_rdata;
  logic                   uart_req;
  logic                   uart_done;
  logic [`SOC_DATA_W-1:0] uart_rdata;
  logic                   uart_err;
  logic                   ctrl_req;
  logic                   ctrl_done;
  logic [`SOC_DATA_W-1:0] ctrl_rdata;

  ////////////////////
  // Decoder
  ////////////////////

  soc_bus_ctrl i_soc_bus_ctrl (
    .clk_i       (clk_i      ),
    .rst_i       (rst_i      ),
    .req_valid_i (req_valid_i),
    .req_addr_i  (req_addr_i ),
    .l2_done_i   (l2_done    ),
    .l2_rdata_i  (l2_rdata   ),
    .uart_done_i (uart_done  ),
    .uart_rdata_i(uart_rdata ),
    .uart_err_i  (uart_err   ),
    .ctrl_done_i (ctrl_done  ),
    .ctrl_rdata_i(ctrl_rdata ),
    .l2_req_o    (l2_req     ),
    .uart_req_o  (uart_req   ),
    .ctrl_req_o  (ctrl_req   ),
    .rsp_valid_o (rsp_valid_o),
    .rsp_rdata_o (rsp_rdata_o),
    .rsp_err_o   (rsp_err_o  )
  );

  ////////////////////
  // Targets
  ////////////////////

  l2_mem i_l2_mem (
    .clk_i      (clk_i      ),
    .rst_i      (rst_i      ),
    .l2_req_i   (l2_req     ),
    .req_we_i   (req_we_i   ),
    .req_addr_i (req_addr_i ),
    .req_wdata_i(req_wdata_i),
    .req_be_i   (req_be_i   ),
    .l2_done_o  (l2_done    ),
    .l2_rdata_o (l2_rdata   )
  );

  // APB has no strobes so byte enables stay unused here
  apb_uart_bridge i_apb_uart_bridge (
    .clk_i         (clk_i         ),
    .rst_i         (rst_i         ),
    .uart_req_i    (uart_req      ),
    .req_we_i      (req_we_i      ),
    .req_addr_i    (req_addr_i    ),
    .req_wdata_i   (req_wdata_i   ),
    .uart_psel_o   (uart_psel_o   ),
    .uart_penable_o(uart_penable_o),
    .uart_pwrite_o (uart_pwrite_o ),
    .uart_paddr_o  (uart_paddr_o  ),
    .uart_pwdata_o (uart_pwdata_o ),
    .uart_prdata_i (uart_prdata_i ),
    .uart_pready_i (uart_pready_i ),
    .uart_pslverr_i(uart_pslverr_i),
    .uart_done_o   (uart_done     ),
    .uart_rdata_o  (uart_rdata    ),
    .uart_err_o    (uart_err      )
  );

  ctrl_regs i_ctrl_regs (
    .clk_i       (clk_i      ),
    .rst_i       (rst_i      ),
    .ctrl_req_i  (ctrl_req   ),
    .req_we_i    (req_we_i   ),
    .req_addr_i  (req_addr_i ),
    .req_wdata_i (req_wdata_i),
    .req_be_i    (req_be_i   ),
    .ctrl_done_o (ctrl_done  ),
    .ctrl_rdata_o(ctrl_rdata ),
    .exit_o      (exit_o     ),
    .hw_cnt_en_o (hw_cnt_en_o)
  );

endmodule : soc_top

//--- verilog/ctrl_regs.sv
// Control registers
`timescale 1ns/100ps
`include "soc_defines.svh"

module ctrl_regs (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   ctrl_req_i,
  input  logic                   req_we_i,
  input  logic [`SOC_ADDR_W-1:0] req_addr_i,
  input  logic [`SOC_DATA_W-1:0] req_wdata_i,
  input  logic [`SOC_STRB_W-1:0] req_be_i,
  output logic                   ctrl_done_o,
  output logic [`SOC_DATA_W-1:0] ctrl_rdata_o,
  output logic [`SOC_DATA_W-1:0] exit_o,
  output logic [`SOC_DATA_W-1:0] hw_cnt_en_o
);

  import soc_pkg::*;

  soc_addr_u              addr;
  logic                   sel_exit;
  logic                   sel_cnt_en;
  logic [`SOC_DATA_W-1:0] exit_q;
  logic [`SOC_DATA_W-1:0] cnt_en_q;
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic                   done_q;

  // Byte-enabled update of one register
  function automatic logic [`SOC_DATA_W-1:0] be_merge(
    input logic [`SOC_DATA_W-1:0] old_v,
    input logic [`SOC_DATA_W-1:0] new_v,
    input logic [`SOC_STRB_W-1:0] be
  );
    logic [`SOC_DATA_W-1:0] res;
    res = old_v;
    for (int b = 0; b < `SOC_STRB_W; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_v[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign addr       = req_addr_i;
  assign sel_exit   = (addr.periph.offset == `CTRL_EXIT_OFS);
  assign sel_cnt_en = (addr.periph.offset == `CTRL_CNT_EN_OFS);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      exit_q   <= '0;
      cnt_en_q <= '0;
      done_q   <= 1'b0;
    end else begin
      done_q <= ctrl_req_i;
      if (ctrl_req_i && req_we_i && sel_exit) begin
        exit_q <= be_merge(exit_q, req_wdata_i, req_be_i);
      end
      if (ctrl_req_i && req_we_i && sel_cnt_en) begin
        cnt_en_q <= be_merge(cnt_en_q, req_wdata_i, req_be_i);
      end
    end
  end

  // Unmapped offsets read as zero
  always_ff @(posedge clk_i) begin
    if (ctrl_req_i) begin
      rdata_q <= sel_exit ? exit_q : (sel_cnt_en ? cnt_en_q : '0);
    end
  end

  assign ctrl_done_o  = done_q;
  assign ctrl_rdata_o = rdata_q;
  assign exit_o       = exit_q;
  assign hw_cnt_en_o  = cnt_en_q;

endmodule : ctrl_regs

//--- verilog/apb_uart_bridge.sv
// APB bridge to the UART
`timescale 1ns/100ps
`include "soc_defines.svh"

module apb_uart_bridge (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   uart_req_i,
  input  logic                   req_we_i,
  input  logic [`SOC_ADDR_W-1:0] req_addr_i,
  input  logic [`SOC_DATA_W-1:0] req_wdata_i,
  output logic                   uart_psel_o,
  output logic                   uart_penable_o,
  output logic                   uart_pwrite_o,
  output logic [`SOC_ADDR_W-1:0] uart_paddr_o,
  output logic [`APB_DATA_W-1:0] uart_pwdata_o,
  input  logic [`APB_DATA_W-1:0] uart_prdata_i,
  input  logic                   uart_pready_i,
  input  logic                   uart_pslverr_i,
  output logic                   uart_done_o,
  output logic [`SOC_DATA_W-1:0] uart_rdata_o,
  output logic                   uart_err_o
);

  import soc_pkg::*;

  localparam logic [1:0] ST_IDLE   = 2'd0;
  localparam logic [1:0] ST_SETUP  = 2'd1;
  localparam logic [1:0] ST_ACCESS = 2'd2;

  soc_addr_u              addr;
  logic [1:0]             state_q;
  logic                   start;
  logic                   finish;
  logic                   hi_q;
  logic                   pwrite_q;
  logic [`SOC_ADDR_W-1:0] paddr_q;
  logic [`APB_DATA_W-1:0] pwdata_q;
  logic [`SOC_DATA_W-1:0] rdata_q;
  logic                   done_q;
  logic                   err_q;

  assign addr   = req_addr_i;
  assign start  = (state_q == ST_IDLE) & uart_req_i;
  assign finish = (state_q == ST_ACCESS) & uart_pready_i;

  ////////////////////
  // APB FSM
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      done_q <= finish;
      case (state_q)
        ST_IDLE:   if (start) state_q <= ST_SETUP;
        ST_SETUP:  state_q <= ST_ACCESS;
        ST_ACCESS: if (uart_pready_i) state_q <= ST_IDLE;
        default:   state_q <= ST_IDLE;
      endcase
      if (finish) begin
        err_q <= uart_pslverr_i;
      end
    end
  end

  // Address bit 2 selects the 32-bit lane
  always_ff @(posedge clk_i) begin
    if (start) begin
      hi_q     <= addr.mem.byte_ofs[2];
      pwrite_q <= req_we_i;
      paddr_q  <= `UART_BASE + 32'(addr.periph.offset);
      pwdata_q <= addr.mem.byte_ofs[2] ? req_wdata_i[63:32] : req_wdata_i[31:0];
    end
    if (finish) begin
      rdata_q <= hi_q ? {uart_prdata_i, 32'b0} : {32'b0, uart_prdata_i};
    end
  end

  assign uart_psel_o    = (state_q != ST_IDLE);
  assign uart_penable_o = (state_q == ST_ACCESS);
  assign uart_pwrite_o  = pwrite_q;
  assign uart_paddr_o   = paddr_q;
  assign uart_pwdata_o  = pwdata_q;
  assign uart_done_o    = done_q;
  assign uart_rdata_o   = rdata_q;
  assign uart_err_o     = err_q;

endmodule : apb_uart_bridge

//--- verilog/l2_mem.sv
// L2 memory
`timescale 1ns/100ps
`include "soc_defines.svh"

module l2_mem (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   l2_req_i,
  input  logic                   req_we_i,
  input  logic [`SOC_ADDR_W-1:0] req_addr_i,
  input  logic [`SOC_DATA_W-1:0] req_wdata_i,
  input  logic [`SOC_STRB_W-1:0] req_be_i,
  output logic                   l2_done_o,
  output logic [`SOC_DATA_W-1:0] l2_rdata_o
);

  import soc_pkg::*;

  soc_addr_u                    addr;
  logic [$clog2(`L2_WORDS)-1:0] index;
  logic [`SOC_DATA_W-1:0]       mem_q [`L2_WORDS];
  logic [`SOC_DATA_W-1:0]       rdata_q;
  logic                         done_q;

  assign addr  = req_addr_i;
  assign index = addr.mem.index;

  ////////////////////
  // Storage
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (l2_req_i) begin
      if (req_we_i) begin
        for (int b = 0; b < `SOC_STRB_W; b++) begin
          if (req_be_i[b]) begin
            mem_q[index][8*b +: 8] <= req_wdata_i[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem_q[index];
      end
    end
  end

  // Fixed one-cycle latency
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= l2_req_i;
    end
  end

  assign l2_done_o  = done_q;
  assign l2_rdata_o = rdata_q;

endmodule : l2_mem

//--- verilog/soc_bus_ctrl.sv
// Host bus decoder and response
`timescale 1ns/100ps
`include "soc_defines.svh"

module soc_bus_ctrl (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   req_valid_i,
  input  logic [`SOC_ADDR_W-1:0] req_addr_i,
  input  logic                   l2_done_i,
  input  logic [`SOC_DATA_W-1:0] l2_rdata_i,
  input  logic                   uart_done_i,
  input  logic [`SOC_DATA_W-1:0] uart_rdata_i,
  input  logic                   uart_err_i,
  input  logic                   ctrl_done_i,
  input  logic [`SOC_DATA_W-1:0] ctrl_rdata_i,
  output logic                   l2_req_o,
  output logic                   uart_req_o,
  output logic                   ctrl_req_o,
  output logic                   rsp_valid_o,
  output logic [`SOC_DATA_W-1:0] rsp_rdata_o,
  output logic                   rsp_err_o
);

  import soc_pkg::*;

  soc_region_e            region;
  logic                   busy_q;
  logic                   accept;
  logic                   err_done_q;
  logic                   done_any;
  logic                   rsp_valid_q;
  logic                   rsp_err_q;
  logic [`SOC_DATA_W-1:0] rsp_rdata_q;

  ////////////////////
  // Address decode
  ////////////////////

  always_comb begin
    region = REGION_NONE;
    if (req_addr_i >= `DRAM_BASE && req_addr_i < `DRAM_BASE + `DRAM_LEN) begin
      region = REGION_L2;
    end else if (req_addr_i >= `UART_BASE && req_addr_i < `UART_BASE + `PERIPH_LEN) begin
      region = REGION_UART;
    end else if (req_addr_i >= `CTRL_BASE && req_addr_i < `CTRL_BASE + `PERIPH_LEN) begin
      region = REGION_CTRL;
    end
  end

  // Strobes while a request is in flight are dropped
  assign accept     = req_valid_i & ~busy_q;
  assign l2_req_o   = accept & (region == REGION_L2);
  assign uart_req_o = accept & (region == REGION_UART);
  assign ctrl_req_o = accept & (region == REGION_CTRL);

  assign done_any = l2_done_i | uart_done_i | ctrl_done_i | err_done_q;

  ////////////////////
  // Tracking
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q      <= 1'b0;
      err_done_q  <= 1'b0;
      rsp_valid_q <= 1'b0;
      rsp_err_q   <= 1'b0;
    end else begin
      err_done_q  <= accept & (region == REGION_NONE);
      rsp_valid_q <= done_any;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done_any) begin
        busy_q <= 1'b0;
      end
      if (done_any) begin
        rsp_err_q <= err_done_q | (uart_done_i & uart_err_i);
      end
    end
  end

  // Error responses carry zero data
  always_ff @(posedge clk_i) begin
    if (l2_done_i) begin
      rsp_rdata_q <= l2_rdata_i;
    end else if (uart_done_i) begin
      rsp_rdata_q <= uart_err_i ? '0 : uart_rdata_i;
    end else if (ctrl_done_i) begin
      rsp_rdata_q <= ctrl_rdata_i;
    end else if (err_done_q) begin
      rsp_rdata_q <= '0;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rsp_rdata_q;
  assign rsp_err_o   = rsp_err_q;

endmodule : soc_bus_ctrl

//--- verilog/soc_pkg.sv
// SoC bus fabric types
package soc_pkg;

  `include "soc_defines.svh"

  ////////////////////
  // Decoded target
  ////////////////////

  typedef enum logic [1:0] {
    REGION_L2   = 2'd0,
    REGION_UART = 2'd1,
    REGION_CTRL = 2'd2,
    REGION_NONE = 2'd3
  } soc_region_e;

  ////////////////////
  // Address word
  ////////////////////

  // L2 sees word index and byte offset, peripherals see page and register offset
  typedef union packed {
    struct packed {
      logic [`SOC_ADDR_W-$clog2(`L2_WORDS)-$clog2(`SOC_STRB_W)-1:0] upper;
      logic [$clog2(`L2_WORDS)-1:0]                                 index;
      logic [$clog2(`SOC_STRB_W)-1:0]                               byte_ofs;
    } mem;
    struct packed {
      logic [`SOC_ADDR_W-13:0] page;
      logic [11:0]             offset;
    } periph;
  } soc_addr_u;

endpackage : soc_pkg

//--- verilog/soc_defines.svh
// SoC bus fabric parameters
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

////////////////////
// Bus widths
////////////////////

`define SOC_ADDR_W 32
`define SOC_DATA_W 64
`define SOC_STRB_W 8
`define APB_DATA_W 32

////////////////////
// Memory map
////////////////////

// L2 depth in 64-bit words
`define L2_WORDS   1024
`define DRAM_BASE  32'h8000_0000
`define DRAM_LEN   (`L2_WORDS * `SOC_STRB_W)
`define UART_BASE  32'hC000_0000
`define CTRL_BASE  32'hD000_0000
`define PERIPH_LEN 32'h0000_1000

// Control register offsets
`define CTRL_EXIT_OFS   12'h000
`define CTRL_CNT_EN_OFS 12'h008

`endif
